// ==== hw/btb_pkg.sv ====
/*
    branch target buffer package
    geometry, vector types, entry layout and the address hashes
    shared by the BTB storage, replacement and top level
*/

`default_nettype none

package btb_pkg;

    // ----------------------------------------
    // geometry
    // ----------------------------------------

    localparam int FETCH_LANES     = 4;
    localparam int LOG_FETCH_LANES = 2;
    localparam int BTB_SETS        = 16;
    localparam int LOG_BTB_SETS    = 4;
    localparam int BTB_ASSOC       = 4;
    localparam int LOG_BTB_ASSOC   = 2;
    localparam int TAG_BITS        = 8;

    localparam int PC_BITS     = 38;
    localparam int ASID_BITS   = 9;
    localparam int ACTION_BITS = 3;
    localparam int TARGET_BITS = 13;
    localparam int PLRU_BITS   = BTB_ASSOC - 1;

    // one entry is info plus tag, padded to whole bytes
    localparam int ENTRY_BITS  = ACTION_BITS + TARGET_BITS + TAG_BITS;
    localparam int ENTRY_BYTES = ENTRY_BITS / 8;
    localparam int SET_BYTES   = FETCH_LANES * BTB_ASSOC * ENTRY_BYTES;

    // plru words are indexed by {set, lane}
    localparam int PLRU_IDX_BITS = LOG_BTB_SETS + LOG_FETCH_LANES;
    localparam int PLRU_WORDS    = BTB_SETS * FETCH_LANES;

    // ----------------------------------------
    // types
    // ----------------------------------------

    typedef logic [PC_BITS-1:0]                 pc38_t;
    typedef logic [ASID_BITS-1:0]               asid_t;
    typedef logic [PC_BITS-LOG_FETCH_LANES-1:0] fetch_idx_t;
    typedef logic [LOG_FETCH_LANES-1:0]         fetch_lane_t;
    typedef logic [LOG_BTB_SETS-1:0]            btb_idx_t;
    typedef logic [TAG_BITS-1:0]                btb_tag_t;
    typedef logic [LOG_BTB_ASSOC-1:0]           btb_way_idx_t;
    typedef logic [PLRU_BITS-1:0]               btb_plru_t;

    // action of zero marks an empty slot
    typedef struct packed {
        logic [ACTION_BITS-1:0] action;
        logic [TARGET_BITS-1:0] target;
    } btb_info_t;

    typedef struct packed {
        btb_info_t info;
        btb_tag_t  tag;
    } btb_entry_t;

    typedef btb_entry_t [FETCH_LANES-1:0][BTB_ASSOC-1:0] btb_set_t;

    typedef logic [FETCH_LANES-1:0][BTB_ASSOC-1:0][ENTRY_BYTES-1:0] btb_byten_t;

    // ----------------------------------------
    // hashes
    // ----------------------------------------

    // set index from the pc bits just above the lane, folded with the asid
    function automatic btb_idx_t index_hash(pc38_t pc38, asid_t asid);
        index_hash = pc38[LOG_FETCH_LANES +: LOG_BTB_SETS] ^ asid[LOG_BTB_SETS-1:0];
    endfunction

    // tag from the pc bits above the set index
    function automatic btb_tag_t tag_hash(pc38_t pc38, asid_t asid);
        tag_hash = pc38[LOG_FETCH_LANES+LOG_BTB_SETS +: TAG_BITS] ^ asid[TAG_BITS-1:0];
    endfunction

    function automatic fetch_lane_t fetch_lane_bits(pc38_t pc38);
        fetch_lane_bits = pc38[LOG_FETCH_LANES-1:0];
    endfunction

endpackage

`default_nettype wire

// ==== hw/plru_updater.sv ====
/*
    tree pseudo-LRU updater for one four-way lane
    finds the victim way and returns the state after a fill or a touch
*/

`timescale 1ns/1ps
`default_nettype none

module plru_updater (
    input  btb_pkg::btb_plru_t    plru_in,
    input  logic                  new_valid,
    input  logic                  touch_valid,
    input  btb_pkg::btb_way_idx_t touch_index,
    output btb_pkg::btb_way_idx_t new_index,
    output btb_pkg::btb_plru_t    plru_out
);

    // way whose path gets flipped
    btb_pkg::btb_way_idx_t path_way;

    // ----------------------------------------
    // victim search
    // ----------------------------------------

    // bit 2 picks the half, bit 1 the low pair, bit 0 the high pair
    always_comb begin
        if (plru_in[2] == 1'b0) begin
            new_index = {1'b0, plru_in[1]};
        end
        else begin
            new_index = {1'b1, plru_in[0]};
        end
    end

    // ----------------------------------------
    // state update
    // ----------------------------------------

    // a fill also counts as a touch of the victim
    always_comb begin
        if (new_valid) begin
            path_way = new_index;
        end
        else begin
            path_way = touch_index;
        end
    end

    always_comb begin
        plru_out = plru_in;
        if (new_valid || touch_valid) begin
            // point the root at the other half
            plru_out[2] = ~path_way[1];
            // and the leaf at the sibling way
            if (path_way[1] == 1'b0) begin
                plru_out[1] = ~path_way[0];
            end
            else begin
                plru_out[0] = ~path_way[0];
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/plru_table.sv ====
/*
    PLRU state table
    one word per set and lane, combinational read, clocked write
*/

`timescale 1ns/1ps
`default_nettype none

module plru_table (
    input  logic                                 CLK,
    input  logic                                 rst_n,
    input  logic [btb_pkg::PLRU_IDX_BITS-1:0]    rindex,
    input  logic                                 wen,
    input  logic [btb_pkg::PLRU_IDX_BITS-1:0]    windex,
    input  btb_pkg::btb_plru_t                   wdata,
    output btb_pkg::btb_plru_t                   rdata
);

    btb_pkg::btb_plru_t plru_mem [btb_pkg::PLRU_WORDS];

    // cleared so every lane starts filling at way 0
    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            for (int i = 0; i < btb_pkg::PLRU_WORDS; i++) begin
                plru_mem[i] <= '0;
            end
        end
        else if (wen) begin
            plru_mem[windex] <= wdata;
        end
    end

    // read in the same cycle as the update that uses it
    assign rdata = plru_mem[rindex];

endmodule

`default_nettype wire

// ==== hw/btb_set_ram.sv ====
/*
    BTB set storage
    one full set per index, registered read, byte-granular write,
    cleared by reset so the buffer starts empty
*/

`timescale 1ns/1ps
`default_nettype none

module btb_set_ram (
    input  logic                  CLK,
    input  logic                  rst_n,
    input  logic                  ren,
    input  btb_pkg::btb_idx_t     rindex,
    input  btb_pkg::btb_byten_t   wen_byte,
    input  btb_pkg::btb_idx_t     windex,
    input  btb_pkg::btb_set_t     wdata,
    output btb_pkg::btb_set_t     rdata
);

    // ----------------------------------------
    // byte views
    // ----------------------------------------

    // byte b covers entry b/3 of the set, lane major
    logic [btb_pkg::SET_BYTES-1:0]      wen_flat;
    logic [btb_pkg::SET_BYTES-1:0][7:0] wdata_bytes;

    logic [btb_pkg::SET_BYTES-1:0][7:0] set_mem [btb_pkg::BTB_SETS];

    assign wen_flat    = wen_byte;
    assign wdata_bytes = wdata;

    // ----------------------------------------
    // storage
    // ----------------------------------------

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            for (int s = 0; s < btb_pkg::BTB_SETS; s++) begin
                set_mem[s] <= '0;
            end
            rdata <= '0;
        end
        else begin
            // old contents on a same-index collision
            if (ren) begin
                rdata <= set_mem[rindex];
            end
            for (int b = 0; b < btb_pkg::SET_BYTES; b++) begin
                if (wen_flat[b]) begin
                    set_mem[windex][b] <= wdata_bytes[b];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/btb.sv ====
/*
    branch target buffer
    four lanes by four ways per set, one-cycle read response,
    single-cycle update with tree-PLRU allocation,
    index and tag hashed with the address-space id
*/

`timescale 1ns/1ps
`default_nettype none

module btb (
    // clock and reset
    input  logic                   CLK,
    input  logic                   rst_n,

    // architectural state
    input  btb_pkg::asid_t         arch_asid,

    // read request
    input  logic                   read_req_valid,
    input  btb_pkg::fetch_idx_t    read_req_fetch_index,

    // read response
    input  btb_pkg::pc38_t         read_resp_pc38,
    output btb_pkg::btb_info_t     [btb_pkg::FETCH_LANES-1:0] read_resp_btb_info_by_lane,
    output logic                   [btb_pkg::FETCH_LANES-1:0] read_resp_hit_by_lane,
    output btb_pkg::btb_way_idx_t  [btb_pkg::FETCH_LANES-1:0] read_resp_hit_way_by_lane,

    // update from the back end
    input  logic                   update_valid,
    input  btb_pkg::pc38_t         update_pc38,
    input  btb_pkg::btb_info_t     update_btb_info,
    input  logic                   update_hit,
    input  btb_pkg::btb_way_idx_t  update_hit_way
);

    // ----------------------------------------
    // signals
    // ----------------------------------------

    // set ram ports
    btb_pkg::btb_idx_t      ram_rindex;
    btb_pkg::btb_set_t      ram_rdata;
    btb_pkg::btb_byten_t    ram_wen_byte;
    btb_pkg::btb_set_t      ram_wdata;

    // plru table ports, indexed by {set, lane}
    logic [btb_pkg::PLRU_IDX_BITS-1:0] plru_index;
    btb_pkg::btb_plru_t                plru_rdata;
    btb_pkg::btb_plru_t                plru_wdata;

    // response side
    btb_pkg::btb_tag_t      resp_tag;

    // update side
    btb_pkg::btb_idx_t      update_index;
    btb_pkg::fetch_lane_t   update_lane;
    btb_pkg::btb_tag_t      update_tag;
    btb_pkg::btb_way_idx_t  victim_way;
    btb_pkg::btb_way_idx_t  update_way;
    btb_pkg::btb_entry_t    update_entry;
    logic                   plru_new_valid;
    logic                   plru_touch_valid;

    // ----------------------------------------
    // read path
    // ----------------------------------------

    // request covers a whole fetch block, so lane bits are zero
    assign ram_rindex = btb_pkg::index_hash(
        {read_req_fetch_index, {btb_pkg::LOG_FETCH_LANES{1'b0}}}, arch_asid);

    assign resp_tag = btb_pkg::tag_hash(read_resp_pc38, arch_asid);

    // per-lane hit search
    always_comb begin
        for (int lane = 0; lane < btb_pkg::FETCH_LANES; lane++) begin
            // miss default is way 0
            read_resp_btb_info_by_lane[lane] = ram_rdata[lane][0].info;
            read_resp_hit_by_lane[lane]      = 1'b0;
            read_resp_hit_way_by_lane[lane]  = '0;

            // walk down so the lowest way wins
            for (int way = btb_pkg::BTB_ASSOC - 1; way >= 0; way--) begin
                if ((|ram_rdata[lane][way].info.action)
                        && (ram_rdata[lane][way].tag == resp_tag)) begin
                    read_resp_btb_info_by_lane[lane] = ram_rdata[lane][way].info;
                    read_resp_hit_by_lane[lane]      = 1'b1;
                    read_resp_hit_way_by_lane[lane]  = btb_pkg::btb_way_idx_t'(way);
                end
            end
        end
    end

    // ----------------------------------------
    // update path
    // ----------------------------------------

    assign update_index = btb_pkg::index_hash(update_pc38, arch_asid);
    assign update_lane  = btb_pkg::fetch_lane_bits(update_pc38);
    assign update_tag   = btb_pkg::tag_hash(update_pc38, arch_asid);
    assign plru_index   = {update_index, update_lane};

    // caller's way on a hit, else allocate the victim
    assign update_way = update_hit ? update_hit_way : victim_way;

    assign plru_new_valid   = update_valid && !update_hit;
    assign plru_touch_valid = update_valid && update_hit;

    assign update_entry = '{info: update_btb_info, tag: update_tag};

    // same entry in every slot, the byte enables pick one
    always_comb begin
        ram_wen_byte = '0;
        if (update_valid) begin
            ram_wen_byte[update_lane][update_way] = '1;
        end
        for (int lane = 0; lane < btb_pkg::FETCH_LANES; lane++) begin
            for (int way = 0; way < btb_pkg::BTB_ASSOC; way++) begin
                ram_wdata[lane][way] = update_entry;
            end
        end
    end

    // ----------------------------------------
    // instances
    // ----------------------------------------

    btb_set_ram set_ram_i (
        .CLK      (CLK),
        .rst_n    (rst_n),
        .ren      (read_req_valid),
        .rindex   (ram_rindex),
        .wen_byte (ram_wen_byte),
        .windex   (update_index),
        .wdata    (ram_wdata),
        .rdata    (ram_rdata)
    );

    plru_table plru_table_i (
        .CLK    (CLK),
        .rst_n  (rst_n),
        .rindex (plru_index),
        .wen    (update_valid),
        .windex (plru_index),
        .wdata  (plru_wdata),
        .rdata  (plru_rdata)
    );

    plru_updater plru_updater_i (
        .plru_in     (plru_rdata),
        .new_valid   (plru_new_valid),
        .touch_valid (plru_touch_valid),
        .touch_index (update_hit_way),
        .new_index   (victim_way),
        .plru_out    (plru_wdata)
    );

endmodule

`default_nettype wire

// ==== test/btb_properties.sv ====
/*
    BTB properties
    reset behavior, known hit outputs and update way checks,
    bound into the BTB top level
*/

`timescale 1ns/1ps
`default_nettype none

module btb_properties (
    input logic                                              CLK,
    input logic                                              rst_n,
    input logic                                              read_req_valid,
    input logic [btb_pkg::FETCH_LANES-1:0]                   read_resp_hit_by_lane,
    input btb_pkg::btb_way_idx_t [btb_pkg::FETCH_LANES-1:0]  read_resp_hit_way_by_lane,
    input logic                                              update_valid,
    input logic                                              update_hit,
    input btb_pkg::btb_way_idx_t                             update_hit_way
);

    int unsigned prop_errors = 0;

    // first response after reset comes from a cleared set
    assert property (@(posedge CLK) $rose(rst_n) |=> (read_resp_hit_by_lane == '0))
        else begin
            prop_errors++;
            $error("hit reported in the cycle after reset release");
        end

    assert property (@(posedge CLK) disable iff (!rst_n)
        read_req_valid |=> !$isunknown(read_resp_hit_by_lane)
                           && !$isunknown(read_resp_hit_way_by_lane))
        else begin
            prop_errors++;
            $error("hit outputs unknown in a response cycle");
        end

    assert property (@(posedge CLK) disable iff (!rst_n)
        (update_valid && update_hit) |-> !$isunknown(update_hit_way))
        else begin
            prop_errors++;
            $error("hit update with an unknown way");
        end

    // miss lanes report way 0
    for (genvar l = 0; l < btb_pkg::FETCH_LANES; l++) begin : g_lane
        assert property (@(posedge CLK) disable iff (!rst_n)
            !read_resp_hit_by_lane[l] |-> (read_resp_hit_way_by_lane[l] == '0))
            else begin
                prop_errors++;
                $error("lane %0d reports a hit way without a hit", l);
            end
    end

endmodule

bind btb btb_properties props_i (
    .CLK                       (CLK),
    .rst_n                     (rst_n),
    .read_req_valid            (read_req_valid),
    .read_resp_hit_by_lane     (read_resp_hit_by_lane),
    .read_resp_hit_way_by_lane (read_resp_hit_way_by_lane),
    .update_valid              (update_valid),
    .update_hit                (update_hit),
    .update_hit_way            (update_hit_way)
);

`default_nettype wire

// ==== test/btb_tb.sv ====
/*
    testbench for the branch target buffer
    drives reads and updates and checks each response
    against a model of the sets, tags and PLRU bits
*/

`timescale 1ns/1ps
`default_nettype none

module btb_tb;

    localparam int TIMEOUT_CYCLES = 20;

    logic                                              CLK;
    logic                                              rst_n;
    btb_pkg::asid_t                                    arch_asid;
    logic                                              read_req_valid;
    btb_pkg::fetch_idx_t                               read_req_fetch_index;
    btb_pkg::pc38_t                                    read_resp_pc38;
    btb_pkg::btb_info_t    [btb_pkg::FETCH_LANES-1:0]  read_resp_btb_info_by_lane;
    logic                  [btb_pkg::FETCH_LANES-1:0]  read_resp_hit_by_lane;
    btb_pkg::btb_way_idx_t [btb_pkg::FETCH_LANES-1:0]  read_resp_hit_way_by_lane;
    logic                                              update_valid;
    btb_pkg::pc38_t                                    update_pc38;
    btb_pkg::btb_info_t                                update_btb_info;
    logic                                              update_hit;
    btb_pkg::btb_way_idx_t                             update_hit_way;

    // reference model, [set][lane][way]
    btb_pkg::btb_info_t model_info [16][4][4];
    btb_pkg::btb_tag_t  model_tag  [16][4][4];
    btb_pkg::btb_plru_t model_plru [16][4];

    // expected response of the read in flight
    btb_pkg::btb_info_t    [3:0] exp_info;
    logic                  [3:0] exp_hit;
    btb_pkg::btb_way_idx_t [3:0] exp_way;

    integer seed;
    int     checks;
    int     errors;
    int     tests;
    int     errors_at_start;

    btb dut_i (.*);

    always #5 CLK = ~CLK;

    // ----------------------------------------
    // reference model
    // ----------------------------------------

    function automatic btb_pkg::btb_idx_t set_of(btb_pkg::pc38_t pc, btb_pkg::asid_t asid);
        return pc[5:2] ^ asid[3:0];
    endfunction

    function automatic btb_pkg::btb_tag_t tag_of(btb_pkg::pc38_t pc, btb_pkg::asid_t asid);
        return pc[13:6] ^ asid[7:0];
    endfunction

    function automatic btb_pkg::btb_way_idx_t plru_victim(btb_pkg::btb_plru_t p);
        if (p[2]) begin
            return {1'b1, p[0]};
        end
        return {1'b0, p[1]};
    endfunction

    // path bits point away from the touched way
    function automatic btb_pkg::btb_plru_t plru_touch(btb_pkg::btb_plru_t p,
                                                      btb_pkg::btb_way_idx_t w);
        btb_pkg::btb_plru_t n;
        n = p;
        n[2] = (w < 2);
        if (w < 2) begin
            n[1] = (w == 0);
        end
        else begin
            n[0] = (w == 2);
        end
        return n;
    endfunction

    function automatic btb_pkg::btb_way_idx_t find_way(btb_pkg::pc38_t pc);
        btb_pkg::btb_idx_t s;
        s = set_of(pc, arch_asid);
        for (int w = 0; w < 4; w++) begin
            if (model_info[s][pc[1:0]][w].action != 0
                    && model_tag[s][pc[1:0]][w] == tag_of(pc, arch_asid)) begin
                return btb_pkg::btb_way_idx_t'(w);
            end
        end
        return '0;
    endfunction

    task automatic predict_read(input btb_pkg::pc38_t pc);
        btb_pkg::btb_idx_t s;
        s = set_of(pc, arch_asid);
        for (int l = 0; l < 4; l++) begin
            exp_info[l] = model_info[s][l][0];
            exp_hit[l]  = 1'b0;
            exp_way[l]  = '0;
            for (int w = 0; w < 4; w++) begin
                if (!exp_hit[l] && model_info[s][l][w].action != 0
                        && model_tag[s][l][w] == tag_of(pc, arch_asid)) begin
                    exp_info[l] = model_info[s][l][w];
                    exp_hit[l]  = 1'b1;
                    exp_way[l]  = btb_pkg::btb_way_idx_t'(w);
                end
            end
        end
    endtask

    task automatic model_update(input btb_pkg::pc38_t pc, input btb_pkg::btb_info_t info,
                                input logic hit, input btb_pkg::btb_way_idx_t hit_way);
        btb_pkg::btb_idx_t     s;
        btb_pkg::btb_way_idx_t w;
        s = set_of(pc, arch_asid);
        w = hit ? hit_way : plru_victim(model_plru[s][pc[1:0]]);
        model_info[s][pc[1:0]][w] = info;
        model_tag[s][pc[1:0]][w]  = tag_of(pc, arch_asid);
        model_plru[s][pc[1:0]]    = plru_touch(model_plru[s][pc[1:0]], w);
    endtask

    // ----------------------------------------
    // stimulus and checks
    // ----------------------------------------

    task automatic compare_value(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("Fail at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    // one clock cycle from falling edge to falling edge
    task automatic run_cycle(input logic do_read, input btb_pkg::pc38_t rd_pc,
                             input logic do_upd, input btb_pkg::pc38_t up_pc,
                             input btb_pkg::btb_info_t up_info, input logic up_hit,
                             input btb_pkg::btb_way_idx_t up_way);
        read_req_valid       = do_read;
        read_req_fetch_index = rd_pc[37:2];
        read_resp_pc38       = {rd_pc[37:2], 2'b00};
        update_valid         = do_upd;
        update_pc38          = up_pc;
        update_btb_info      = up_info;
        update_hit           = up_hit;
        update_hit_way       = up_way;
        if (do_read) begin
            predict_read({rd_pc[37:2], 2'b00});
        end
        @(posedge CLK);
        if (do_upd) begin
            model_update(up_pc, up_info, up_hit, up_way);
        end
        @(negedge CLK);
        read_req_valid = 1'b0;
        update_valid   = 1'b0;
        update_hit     = 1'b0;
        if (do_read) begin
            compare_value("read_resp_hit_by_lane", exp_hit, read_resp_hit_by_lane);
            compare_value("read_resp_hit_way_by_lane", exp_way, read_resp_hit_way_by_lane);
            compare_value("read_resp_btb_info_by_lane", exp_info, read_resp_btb_info_by_lane);
        end
    endtask

    task automatic read_block(input btb_pkg::pc38_t pc);
        run_cycle(1'b1, pc, 1'b0, '0, '0, 1'b0, '0);
    endtask

    task automatic write_update(input btb_pkg::pc38_t pc, input btb_pkg::btb_info_t info,
                                input logic hit, input btb_pkg::btb_way_idx_t way);
        run_cycle(1'b0, '0, 1'b1, pc, info, hit, way);
    endtask

    function automatic btb_pkg::pc38_t rand_pc();
        return btb_pkg::pc38_t'({$random(seed), $random(seed)});
    endfunction

    function automatic btb_pkg::btb_info_t rand_info();
        btb_pkg::btb_info_t info;
        info.action = 3'($random(seed)) | 3'b001;
        info.target = 13'($random(seed));
        return info;
    endfunction

    task automatic finish_test(input string name);
        tests++;
        $display("test %0d %s: %s", tests, name, (errors == errors_at_start) ? "ok" : "errors");
        errors_at_start = errors;
    endtask

    initial begin
        btb_pkg::pc38_t     pcs [5];
        btb_pkg::pc38_t     base;
        btb_pkg::btb_info_t info;
        btb_pkg::asid_t     asid_saved;
        int                 fill_order [4];
        int                 wait_cycles;

        fill_order      = '{0, 2, 1, 3};
        seed            = 14154;
        checks          = 0;
        errors          = 0;
        tests           = 0;
        errors_at_start = 0;
        CLK             = 1'b0;
        rst_n           = 1'b0;
        arch_asid       = 9'($random(seed));
        read_req_valid  = 1'b0;
        read_req_fetch_index = '0;
        read_resp_pc38  = '0;
        update_valid    = 1'b0;
        update_pc38     = '0;
        update_btb_info = '0;
        update_hit      = 1'b0;
        update_hit_way  = '0;
        for (int s = 0; s < 16; s++) begin
            for (int l = 0; l < 4; l++) begin
                model_plru[s][l] = '0;
                for (int w = 0; w < 4; w++) begin
                    model_info[s][l][w] = '0;
                    model_tag[s][l][w]  = '0;
                end
            end
        end
        repeat (10) @(negedge CLK);
        rst_n = 1'b1;

        // buffer must come out of reset empty
        wait_cycles = 0;
        while (read_resp_hit_by_lane !== '0) begin
            if (wait_cycles == TIMEOUT_CYCLES) begin
                $display("timeout waiting for the buffer to report no hits after reset");
                $display("SIMULATION FAILED");
                $finish;
            end
            else begin
                wait_cycles++;
                @(negedge CLK);
            end
        end

        for (int i = 0; i < 8; i++) begin
            read_block(rand_pc());
            compare_value("read_resp_hit_by_lane", '0, read_resp_hit_by_lane);
        end
        finish_test("reads after reset miss");

        // four fills of one set and lane
        base = rand_pc();
        for (int i = 0; i < 4; i++) begin
            pcs[i] = base + 38'(i * 64);
            write_update(pcs[i], rand_info(), 1'b0, '0);
            read_block(pcs[i]);
            compare_value("read_resp_hit_by_lane", 64'(1) << base[1:0], read_resp_hit_by_lane);
            compare_value("read_resp_hit_way_by_lane[lane]", 64'(fill_order[i]),
                          read_resp_hit_way_by_lane[base[1:0]]);
        end
        finish_test("miss updates fill ways in PLRU order");

        asid_saved = arch_asid;
        arch_asid  = asid_saved ^ 9'h0a5;
        read_block(pcs[0]);
        compare_value("read_resp_hit_by_lane", '0, read_resp_hit_by_lane);
        arch_asid = asid_saved;
        read_block(pcs[0]);
        compare_value("read_resp_hit_by_lane", 64'(1) << base[1:0], read_resp_hit_by_lane);
        finish_test("asid change hides entries");

        // fresh set and lane, touch way 0 before the fifth fill
        base      = rand_pc();
        base[5:0] = pcs[0][5:0] ^ 6'h15;
        for (int i = 0; i < 5; i++) begin
            pcs[i] = base + 38'(i * 64);
        end
        for (int i = 0; i < 4; i++) begin
            write_update(pcs[i], rand_info(), 1'b0, '0);
        end
        write_update(pcs[0], rand_info(), 1'b1, find_way(pcs[0]));
        write_update(pcs[4], rand_info(), 1'b0, '0);
        for (int i = 0; i < 5; i++) begin
            read_block(pcs[i]);
            compare_value("read_resp_hit_by_lane[lane]", 64'(i != 1),
                          read_resp_hit_by_lane[base[1:0]]);
        end
        finish_test("fifth fill evicts the PLRU victim");

        info = rand_info();
        write_update(pcs[3], info, 1'b1, find_way(pcs[3]));
        read_block(pcs[3]);
        compare_value("read_resp_btb_info_by_lane[lane]", info,
                      read_resp_btb_info_by_lane[base[1:0]]);
        compare_value("read_resp_hit_way_by_lane[lane]", 3, read_resp_hit_way_by_lane[base[1:0]]);
        finish_test("hit update replaces info");

        // same-cycle read sees the old set
        info = rand_info();
        run_cycle(1'b1, pcs[2], 1'b1, pcs[2], info, 1'b1, find_way(pcs[2]));
        read_block(pcs[2]);
        compare_value("read_resp_btb_info_by_lane[lane]", info,
                      read_resp_btb_info_by_lane[base[1:0]]);
        finish_test("same-cycle update and read");

        @(negedge CLK);
        $display("tests: %0d, checks: %0d, errors: %0d, assertion failures: %0d",
                 tests, checks, errors, dut_i.props_i.prop_errors);
        if (errors == 0 && dut_i.props_i.prop_errors == 0) begin
            $display("SIMULATION PASSED");
        end
        else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
hw/btb_pkg.sv
hw/plru_updater.sv
hw/plru_table.sv
hw/btb_set_ram.sv
hw/btb.sv
test/btb_properties.sv
test/btb_tb.sv
